// File: logic/dbg_mam_pkg.sv
// Debug memory access module
// Shared definitions

`default_nettype none

package dbg_mam_pkg;

   // --------------------
   // Network flits
   // --------------------

   localparam int FLIT_WIDTH = 18;
   localparam int CONTENT_WIDTH = 16;

   // Flit type sits in the top two bits
   // Payload is 2'b00 and single is 2'b11
   localparam logic [1:0] FLIT_TYPE_HEADER = 2'b01;
   localparam logic [1:0] FLIT_TYPE_LAST = 2'b10;

   // Packet classes carried in a header
   localparam logic [2:0] CLASS_CONF = 3'b010;
   localparam logic [2:0] CLASS_MEM_WRITE = 3'b111;

   // Content bits, seen either as a header or as a payload half-word
   typedef union packed {
      struct packed {
         logic [4:0] dest;
         logic [2:0] pclass;
         logic [7:0] sub;
      } hdr;
      logic [CONTENT_WIDTH-1:0] payload;
   } flit_content_u;

   // --------------------
   // Register contents
   // --------------------

   localparam logic [7:0] MODULE_TYPE_MAM = 8'h07;
   localparam logic [7:0] MODULE_VERSION_MAM = 8'h00;
   localparam logic [15:0] MEMORY_ID = 16'h0042;

   // --------------------
   // Memory side
   // --------------------

   // Depth must stay a power of two, pointers wrap naturally
   localparam int WRITE_FIFO_DEPTH = 4;
   localparam int WB_ADDR_WIDTH = 32;
   localparam int WB_DATA_WIDTH = 32;
   // Address in the upper half, data in the lower half
   localparam int FIFO_WORD_WIDTH = WB_ADDR_WIDTH + WB_DATA_WIDTH;

   // Receive FSM states
   localparam logic [2:0] CTRL_IDLE = 3'd0;
   localparam logic [2:0] CTRL_CONF_SEND = 3'd1;
   localparam logic [2:0] CTRL_ADDR_HI = 3'd2;
   localparam logic [2:0] CTRL_ADDR_LO = 3'd3;
   localparam logic [2:0] CTRL_DATA_HI = 3'd4;
   localparam logic [2:0] CTRL_DATA_HI_NEXT = 3'd5;
   localparam logic [2:0] CTRL_DATA_LO = 3'd6;

   // Configuration responder states
   localparam logic [1:0] CONF_IDLE = 2'd0;
   localparam logic [1:0] CONF_WAIT_LAST = 2'd1;
   localparam logic [1:0] CONF_SEND_HDR = 2'd2;
   localparam logic [1:0] CONF_SEND_LAST = 2'd3;

   // Wishbone master states
   localparam logic [1:0] WB_IDLE = 2'd0;
   localparam logic [1:0] WB_SETUP = 2'd1;
   localparam logic [1:0] WB_WAIT = 2'd2;

endpackage

`default_nettype wire

// File: logic/dbg_conf_regs.sv
// Configuration register responder

`timescale 1ns/1ns
`default_nettype none

module dbg_conf_regs (
   input  wire                                 clk,
   input  wire                                 rst,
   input  wire  [dbg_mam_pkg::FLIT_WIDTH-1:0]  noc_in_flit_i,
   input  wire                                 conf_in_valid_i,
   input  wire                                 conf_cts_i,
   input  wire                                 conf_out_ready_i,
   output logic                                conf_rts_o,
   output logic                                conf_busy_o,
   output logic                                conf_out_valid_o,
   output logic [dbg_mam_pkg::FLIT_WIDTH-1:0]  conf_out_flit_o
);

   dbg_mam_pkg::flit_content_u in_content;
   dbg_mam_pkg::flit_content_u reply_hdr;
   logic [1:0]  in_type;
   logic [1:0]  state;
   logic [7:0]  index;
   logic [4:0]  requester;
   logic [15:0] reg_value;

   assign in_type = noc_in_flit_i[dbg_mam_pkg::FLIT_WIDTH-1:dbg_mam_pkg::CONTENT_WIDTH];
   assign in_content = noc_in_flit_i[dbg_mam_pkg::CONTENT_WIDTH-1:0];

   // Request decoded, still collecting its last flit
   assign conf_busy_o = (state == dbg_mam_pkg::CONF_WAIT_LAST);
   // Reply pending, flit shown only once the output is granted
   assign conf_rts_o = state[1];
   assign conf_out_valid_o = conf_rts_o & conf_cts_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= dbg_mam_pkg::CONF_IDLE;
      end else begin
         case (state)
            dbg_mam_pkg::CONF_IDLE: begin
               if (conf_in_valid_i && in_type == dbg_mam_pkg::FLIT_TYPE_HEADER &&
                   in_content.hdr.pclass == dbg_mam_pkg::CLASS_CONF) begin
                  state <= dbg_mam_pkg::CONF_WAIT_LAST;
               end
            end
            dbg_mam_pkg::CONF_WAIT_LAST: begin
               // Anything but a last flit drops the request
               if (conf_in_valid_i) begin
                  state <= (in_type == dbg_mam_pkg::FLIT_TYPE_LAST) ?
                           dbg_mam_pkg::CONF_SEND_HDR : dbg_mam_pkg::CONF_IDLE;
               end
            end
            dbg_mam_pkg::CONF_SEND_HDR: begin
               if (conf_out_valid_o && conf_out_ready_i) begin
                  state <= dbg_mam_pkg::CONF_SEND_LAST;
               end
            end
            default: begin
               if (conf_out_valid_o && conf_out_ready_i) begin
                  state <= dbg_mam_pkg::CONF_IDLE;
               end
            end
         endcase
      end
   end

   // Register index from the header, return address from the last flit
   always_ff @(posedge clk) begin
      if (conf_in_valid_i && state == dbg_mam_pkg::CONF_IDLE) begin
         index <= in_content.hdr.sub;
      end
      if (conf_in_valid_i && state == dbg_mam_pkg::CONF_WAIT_LAST) begin
         requester <= in_content.payload[4:0];
      end
   end

   always_comb begin
      case (index)
         8'd0:    reg_value = {dbg_mam_pkg::MODULE_TYPE_MAM, dbg_mam_pkg::MODULE_VERSION_MAM};
         8'd1:    reg_value = dbg_mam_pkg::MEMORY_ID;
         default: reg_value = '0;
      endcase
      // Reply header goes back to the requester, index echoed
      reply_hdr.hdr.dest = requester;
      reply_hdr.hdr.pclass = dbg_mam_pkg::CLASS_CONF;
      reply_hdr.hdr.sub = index;
   end

   assign conf_out_flit_o = (state == dbg_mam_pkg::CONF_SEND_HDR) ?
                            {dbg_mam_pkg::FLIT_TYPE_HEADER, reply_hdr} :
                            {dbg_mam_pkg::FLIT_TYPE_LAST, reg_value};

endmodule

`default_nettype wire

// File: logic/mam_write_fifo.sv
// Memory write FIFO

`timescale 1ns/1ns
`default_nettype none

module mam_write_fifo (
   input  wire                                      clk,
   input  wire                                      rst,
   input  wire  [dbg_mam_pkg::FIFO_WORD_WIDTH-1:0]  in_word_i,
   input  wire                                      in_valid_i,
   input  wire                                      out_ready_i,
   output logic                                     in_ready_o,
   output logic [dbg_mam_pkg::FIFO_WORD_WIDTH-1:0]  out_word_o,
   output logic                                     out_valid_o
);

   logic [dbg_mam_pkg::FIFO_WORD_WIDTH-1:0] mem [dbg_mam_pkg::WRITE_FIFO_DEPTH];
   logic [$clog2(dbg_mam_pkg::WRITE_FIFO_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(dbg_mam_pkg::WRITE_FIFO_DEPTH)-1:0]   rd_ptr;
   logic [$clog2(dbg_mam_pkg::WRITE_FIFO_DEPTH+1)-1:0] count;
   logic push;
   logic pop;

   assign in_ready_o = (count < dbg_mam_pkg::WRITE_FIFO_DEPTH);
   assign out_valid_o = (count != 0);
   assign push = in_valid_i & in_ready_o;
   assign pop = out_valid_o & out_ready_i;

   // Head entry straight from the storage flops
   assign out_word_o = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop keep the count
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_word_i;
      end
   end

endmodule

`default_nettype wire

// File: logic/mam_wb_master.sv
// Wishbone write master

`timescale 1ns/1ns
`default_nettype none

module mam_wb_master (
   input  wire                                        clk,
   input  wire                                        rst,
   input  wire  [dbg_mam_pkg::FIFO_WORD_WIDTH-1:0]    fifo_word_i,
   input  wire                                        fifo_valid_i,
   input  wire                                        wb_ack_i,
   input  wire                                        wb_err_i,
   output logic                                       fifo_ready_o,
   output logic [dbg_mam_pkg::WB_ADDR_WIDTH-1:0]      wb_adr_o,
   output logic [dbg_mam_pkg::WB_DATA_WIDTH-1:0]      wb_dat_o,
   output logic [dbg_mam_pkg::WB_DATA_WIDTH/8-1:0]    wb_sel_o,
   output logic                                       wb_we_o,
   output logic                                       wb_cyc_o,
   output logic                                       wb_stb_o
);

   logic [1:0] state;
   logic       active;

   // Only pops in idle, so a word is never taken mid-cycle
   assign fifo_ready_o = (state == dbg_mam_pkg::WB_IDLE);
   assign active = (state == dbg_mam_pkg::WB_SETUP) | (state == dbg_mam_pkg::WB_WAIT);

   // Classic single write, all byte lanes
   assign wb_cyc_o = active;
   assign wb_stb_o = active;
   assign wb_we_o = active;
   assign wb_sel_o = {(dbg_mam_pkg::WB_DATA_WIDTH/8){active}};

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= dbg_mam_pkg::WB_IDLE;
      end else begin
         case (state)
            dbg_mam_pkg::WB_IDLE: begin
               if (fifo_valid_i) begin
                  state <= dbg_mam_pkg::WB_SETUP;
               end
            end
            // First strobe cycle, then wait, both end on ack or err
            dbg_mam_pkg::WB_SETUP, dbg_mam_pkg::WB_WAIT: begin
               if (wb_ack_i || wb_err_i) begin
                  state <= dbg_mam_pkg::WB_IDLE;
               end else begin
                  state <= dbg_mam_pkg::WB_WAIT;
               end
            end
            default: begin
               state <= dbg_mam_pkg::WB_IDLE;
            end
         endcase
      end
   end

   // Address and data latched on pop, held through the cycle
   always_ff @(posedge clk) begin
      if (fifo_ready_o && fifo_valid_i) begin
         wb_adr_o <= fifo_word_i[dbg_mam_pkg::FIFO_WORD_WIDTH-1:dbg_mam_pkg::WB_DATA_WIDTH];
         wb_dat_o <= fifo_word_i[dbg_mam_pkg::WB_DATA_WIDTH-1:0];
      end
   end

endmodule

`default_nettype wire

// File: logic/mam_ctrl.sv
// Memory access control
// Receive FSM and output arbitration

`timescale 1ns/1ns
`default_nettype none

module mam_ctrl (
   input  wire                                      clk,
   input  wire                                      rst,
   input  wire  [dbg_mam_pkg::FLIT_WIDTH-1:0]       noc_in_flit_i,
   input  wire                                      noc_in_valid_i,
   input  wire                                      noc_out_ready_i,
   input  wire                                      conf_rts_i,
   input  wire                                      conf_busy_i,
   input  wire                                      conf_out_valid_i,
   input  wire  [dbg_mam_pkg::FLIT_WIDTH-1:0]       conf_out_flit_i,
   input  wire                                      fifo_in_ready_i,
   output logic                                     noc_in_ready_o,
   output logic [dbg_mam_pkg::FLIT_WIDTH-1:0]       noc_out_flit_o,
   output logic                                     noc_out_valid_o,
   output logic                                     conf_cts_o,
   output logic                                     conf_out_ready_o,
   output logic                                     conf_in_valid_o,
   output logic [dbg_mam_pkg::FIFO_WORD_WIDTH-1:0]  fifo_in_word_o,
   output logic                                     fifo_in_valid_o
);

   dbg_mam_pkg::flit_content_u in_content;
   logic [1:0] in_type;
   logic [2:0] state;
   logic [2:0] state_next;
   logic       accept;
   logic       write_hdr;
   logic [dbg_mam_pkg::FIFO_WORD_WIDTH-1:0] word;

   assign in_type = noc_in_flit_i[dbg_mam_pkg::FLIT_WIDTH-1:dbg_mam_pkg::CONTENT_WIDTH];
   assign in_content = noc_in_flit_i[dbg_mam_pkg::CONTENT_WIDTH-1:0];

   // --------------------
   // Input side
   // --------------------

   // Stall while the responder owns the output or the FIFO is full
   assign noc_in_ready_o = (state != dbg_mam_pkg::CTRL_CONF_SEND) & fifo_in_ready_i;
   assign accept = noc_in_valid_i & noc_in_ready_o;

   // Every flit taken in idle is offered to the responder too
   assign conf_in_valid_o = (state == dbg_mam_pkg::CTRL_IDLE) & accept;

   // Write header, unless the flit belongs to a config request in progress
   assign write_hdr = (in_type == dbg_mam_pkg::FLIT_TYPE_HEADER) &&
                      (in_content.hdr.pclass == dbg_mam_pkg::CLASS_MEM_WRITE) &&
                      (in_content.hdr.sub == 8'h00) && !conf_busy_i;

   // --------------------
   // Output side
   // --------------------

   // Responder is the only source, granted in CONF_SEND
   assign conf_cts_o = (state == dbg_mam_pkg::CTRL_CONF_SEND);
   assign conf_out_ready_o = conf_cts_o & noc_out_ready_i;
   assign noc_out_valid_o = conf_cts_o & conf_out_valid_i;
   assign noc_out_flit_o = conf_out_flit_i;

   always_comb begin
      state_next = state;
      case (state)
         dbg_mam_pkg::CTRL_IDLE: begin
            // Grant only with no flit waiting, it would be taken otherwise
            if (!noc_in_valid_i && conf_rts_i) begin
               state_next = dbg_mam_pkg::CTRL_CONF_SEND;
            end else if (accept && write_hdr) begin
               state_next = dbg_mam_pkg::CTRL_ADDR_HI;
            end
         end
         dbg_mam_pkg::CTRL_CONF_SEND: begin
            if (!conf_rts_i && !conf_out_valid_i) begin
               state_next = dbg_mam_pkg::CTRL_IDLE;
            end
         end
         dbg_mam_pkg::CTRL_ADDR_HI: begin
            if (accept) begin
               state_next = dbg_mam_pkg::CTRL_ADDR_LO;
            end
         end
         dbg_mam_pkg::CTRL_ADDR_LO: begin
            if (accept) begin
               state_next = dbg_mam_pkg::CTRL_DATA_HI;
            end
         end
         dbg_mam_pkg::CTRL_DATA_HI, dbg_mam_pkg::CTRL_DATA_HI_NEXT: begin
            if (accept) begin
               state_next = dbg_mam_pkg::CTRL_DATA_LO;
            end
         end
         dbg_mam_pkg::CTRL_DATA_LO: begin
            // Last flit ends the packet, otherwise another pair follows
            if (accept) begin
               state_next = (in_type == dbg_mam_pkg::FLIT_TYPE_LAST) ?
                            dbg_mam_pkg::CTRL_IDLE : dbg_mam_pkg::CTRL_DATA_HI_NEXT;
            end
         end
         default: begin
            state_next = dbg_mam_pkg::CTRL_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= dbg_mam_pkg::CTRL_IDLE;
         fifo_in_valid_o <= 1'b0;
      end else begin
         state <= state_next;
         // Push one cycle after the low data half
         fifo_in_valid_o <= accept && (state == dbg_mam_pkg::CTRL_DATA_LO);
      end
   end

   // Word assembly, most significant half first
   always_ff @(posedge clk) begin
      if (accept) begin
         case (state)
            dbg_mam_pkg::CTRL_ADDR_HI: word[63:48] <= in_content.payload;
            dbg_mam_pkg::CTRL_ADDR_LO: word[47:32] <= in_content.payload;
            dbg_mam_pkg::CTRL_DATA_HI: word[31:16] <= in_content.payload;
            dbg_mam_pkg::CTRL_DATA_HI_NEXT: begin
               // Next pair lands one word further on
               word[63:32] <= word[63:32] + 32'd4;
               word[31:16] <= in_content.payload;
            end
            dbg_mam_pkg::CTRL_DATA_LO: word[15:0] <= in_content.payload;
            default: begin
            end
         endcase
      end
   end

   assign fifo_in_word_o = word;

endmodule

`default_nettype wire

// File: logic/dbg_mam.sv
// Debug memory access module

`timescale 1ns/1ns
`default_nettype none

module dbg_mam (
   input  wire                                      clk,
   input  wire                                      rst,
   input  wire  [dbg_mam_pkg::FLIT_WIDTH-1:0]       noc_in_flit_i,
   input  wire                                      noc_in_valid_i,
   output logic                                     noc_in_ready_o,
   output logic [dbg_mam_pkg::FLIT_WIDTH-1:0]       noc_out_flit_o,
   output logic                                     noc_out_valid_o,
   input  wire                                      noc_out_ready_i,
   output logic [dbg_mam_pkg::WB_ADDR_WIDTH-1:0]    wb_adr_o,
   output logic [dbg_mam_pkg::WB_DATA_WIDTH-1:0]    wb_dat_o,
   output logic [dbg_mam_pkg::WB_DATA_WIDTH/8-1:0]  wb_sel_o,
   output logic                                     wb_we_o,
   output logic                                     wb_cyc_o,
   output logic                                     wb_stb_o,
   input  wire                                      wb_ack_i,
   input  wire                                      wb_err_i
);

   // Responder links
   logic conf_rts;
   logic conf_cts;
   logic conf_busy;
   logic conf_in_valid;
   logic conf_out_valid;
   logic conf_out_ready;
   logic [dbg_mam_pkg::FLIT_WIDTH-1:0] conf_out_flit;

   // FIFO links
   logic [dbg_mam_pkg::FIFO_WORD_WIDTH-1:0] fifo_in_word;
   logic [dbg_mam_pkg::FIFO_WORD_WIDTH-1:0] fifo_out_word;
   logic fifo_in_valid;
   logic fifo_in_ready;
   logic fifo_out_valid;
   logic fifo_out_ready;

   mam_ctrl u_ctrl (
      .clk              (clk),
      .rst              (rst),
      .noc_in_flit_i    (noc_in_flit_i),
      .noc_in_valid_i   (noc_in_valid_i),
      .noc_out_ready_i  (noc_out_ready_i),
      .conf_rts_i       (conf_rts),
      .conf_busy_i      (conf_busy),
      .conf_out_valid_i (conf_out_valid),
      .conf_out_flit_i  (conf_out_flit),
      .fifo_in_ready_i  (fifo_in_ready),
      .noc_in_ready_o   (noc_in_ready_o),
      .noc_out_flit_o   (noc_out_flit_o),
      .noc_out_valid_o  (noc_out_valid_o),
      .conf_cts_o       (conf_cts),
      .conf_out_ready_o (conf_out_ready),
      .conf_in_valid_o  (conf_in_valid),
      .fifo_in_word_o   (fifo_in_word),
      .fifo_in_valid_o  (fifo_in_valid)
   );

   dbg_conf_regs u_conf_regs (
      .clk              (clk),
      .rst              (rst),
      .noc_in_flit_i    (noc_in_flit_i),
      .conf_in_valid_i  (conf_in_valid),
      .conf_cts_i       (conf_cts),
      .conf_out_ready_i (conf_out_ready),
      .conf_rts_o       (conf_rts),
      .conf_busy_o      (conf_busy),
      .conf_out_valid_o (conf_out_valid),
      .conf_out_flit_o  (conf_out_flit)
   );

   mam_write_fifo u_write_fifo (
      .clk         (clk),
      .rst         (rst),
      .in_word_i   (fifo_in_word),
      .in_valid_i  (fifo_in_valid),
      .out_ready_i (fifo_out_ready),
      .in_ready_o  (fifo_in_ready),
      .out_word_o  (fifo_out_word),
      .out_valid_o (fifo_out_valid)
   );

   mam_wb_master u_wb_master (
      .clk          (clk),
      .rst          (rst),
      .fifo_word_i  (fifo_out_word),
      .fifo_valid_i (fifo_out_valid),
      .wb_ack_i     (wb_ack_i),
      .wb_err_i     (wb_err_i),
      .fifo_ready_o (fifo_out_ready),
      .wb_adr_o     (wb_adr_o),
      .wb_dat_o     (wb_dat_o),
      .wb_sel_o     (wb_sel_o),
      .wb_we_o      (wb_we_o),
      .wb_cyc_o     (wb_cyc_o),
      .wb_stb_o     (wb_stb_o)
   );

endmodule

`default_nettype wire

// File: dv/dbg_mam_asserts.sv
// Memory access protocol checks

`timescale 1ns/1ns
`default_nettype none

module dbg_mam_asserts (
   input wire                                   clk,
   input wire                                   rst,
   input wire                                   cyc_i,
   input wire                                   stb_i,
   input wire                                   we_i,
   input wire                                   ack_i,
   input wire                                   err_i,
   input wire [dbg_mam_pkg::WB_ADDR_WIDTH-1:0]  adr_i,
   input wire [dbg_mam_pkg::WB_DATA_WIDTH-1:0]  dat_i,
   input wire                                   out_valid_i,
   input wire                                   out_ready_i,
   input wire [dbg_mam_pkg::FLIT_WIDTH-1:0]     out_flit_i,
   input wire                                   in_ready_i
);

   int fail_count = 0;

   // --------------------
   // Wishbone side
   // --------------------

   // Strobe only inside a cycle
   stb_in_cyc: assert property (@(posedge clk) disable iff (rst) stb_i |-> cyc_i)
      else begin
         fail_count++;
         $error("wb_stb_o high outside a Wishbone cycle");
      end

   // Strobe held until the slave ends the cycle
   stb_held: assert property (@(posedge clk) disable iff (rst)
         stb_i && !ack_i && !err_i |=> stb_i)
      else begin
         fail_count++;
         $error("wb_stb_o dropped before ack or err");
      end

   stb_bus_stable: assert property (@(posedge clk) disable iff (rst)
         stb_i && !ack_i && !err_i |=> $stable(adr_i) && $stable(dat_i))
      else begin
         fail_count++;
         $error("wb_adr_o/wb_dat_o changed mid-cycle, now %h %h", adr_i, dat_i);
      end

   // --------------------
   // Network side
   // --------------------

   // Reply flit parked until taken
   out_held: assert property (@(posedge clk) disable iff (rst)
         out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_flit_i))
      else begin
         fail_count++;
         $error("noc_out_flit_o not held while waiting, now %h", out_flit_i);
      end

   // First cycle out of reset is quiet
   reset_quiet: assert property (@(posedge clk)
         $fell(rst) |-> !cyc_i && !stb_i && !we_i && !out_valid_i && in_ready_i)
      else begin
         fail_count++;
         $error("outputs active right after reset");
      end

endmodule

bind dbg_mam dbg_mam_asserts u_asserts (
   .clk         (clk),
   .rst         (rst),
   .cyc_i       (wb_cyc_o),
   .stb_i       (wb_stb_o),
   .we_i        (wb_we_o),
   .ack_i       (wb_ack_i),
   .err_i       (wb_err_i),
   .adr_i       (wb_adr_o),
   .dat_i       (wb_dat_o),
   .out_valid_i (noc_out_valid_o),
   .out_ready_i (noc_out_ready_i),
   .out_flit_i  (noc_out_flit_o),
   .in_ready_i  (noc_in_ready_o)
);

`default_nettype wire

// File: dv/dbg_mam_tb.sv
// Debug memory access testbench

`timescale 1ns/1ns
`default_nettype none

module dbg_mam_tb;

   localparam int CLK_PERIOD = 8;
   localparam logic [1:0] TYPE_PAYLOAD = 2'b00;
   localparam logic [4:0] MAM_ADDR = 5'd4;
   localparam int BURST_PAIRS = 5;
   // Long enough to fill the FIFO twice over
   localparam int STALL_PAIRS = 2 * dbg_mam_pkg::WRITE_FIFO_DEPTH + 2;
   localparam int SLOW_ACK_DELAY = 8;
   localparam int TOTAL_WORDS = 1 + BURST_PAIRS + 1 + STALL_PAIRS;
   localparam int CONF_READS = 4;
   // Slow ack plus setup, idle and push latency
   localparam int WORST_CYCLES_PER_WORD = SLOW_ACK_DELAY + 4;
   localparam int TIMEOUT_CYCLES = TOTAL_WORDS * WORST_CYCLES_PER_WORD + CONF_READS * 20 + 200;

   logic clk;
   logic rst;
   logic [dbg_mam_pkg::FLIT_WIDTH-1:0] noc_in_flit_i;
   logic noc_in_valid_i;
   logic noc_in_ready_o;
   logic [dbg_mam_pkg::FLIT_WIDTH-1:0] noc_out_flit_o;
   logic noc_out_valid_o;
   logic noc_out_ready_i;
   logic [dbg_mam_pkg::WB_ADDR_WIDTH-1:0] wb_adr_o;
   logic [dbg_mam_pkg::WB_DATA_WIDTH-1:0] wb_dat_o;
   logic [3:0] wb_sel_o;
   logic wb_we_o;
   logic wb_cyc_o;
   logic wb_stb_o;
   logic wb_ack_i = 1'b0;
   logic wb_err_i;

   // Expected traffic, heads mirrored into plain signals for the assertions
   logic [63:0] write_q[$];
   logic [dbg_mam_pkg::FLIT_WIDTH-1:0] reply_q[$];
   logic exp_write_any = 1'b0;
   logic exp_reply_any = 1'b0;
   logic [31:0] exp_adr;
   logic [31:0] exp_dat;
   logic [dbg_mam_pkg::FLIT_WIDTH-1:0] exp_flit;

   logic [31:0] data_lfsr = 32'd84347;
   logic [31:0] ack_lfsr = 32'd84347;
   logic slow_ack = 1'b0;
   logic ack_armed = 1'b0;
   int ack_delay;
   int ack_count = 0;
   int stall_count = 0;
   int write_errors = 0;
   int reply_errors = 0;
   int other_errors = 0;
   int protocol_errors;

   dbg_mam dut0 (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   // --------------------
   // Helpers
   // --------------------

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] take_bits(inout logic [31:0] state, input int count);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < count; i++) begin
         state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
         bits = {bits[30:0], state[0]};
      end
      return bits;
   endfunction

   function automatic void update_heads();
      exp_write_any = (write_q.size() != 0);
      exp_reply_any = (reply_q.size() != 0);
      if (exp_write_any) begin
         exp_adr = write_q[0][63:32];
         exp_dat = write_q[0][31:0];
      end
      if (exp_reply_any) begin
         exp_flit = reply_q[0];
      end
   endfunction

   // Register map: 0 type/version, 1 memory id, rest reads zero
   function automatic logic [15:0] expected_reg(input logic [7:0] index);
      if (index == 8'd0) begin
         return {dbg_mam_pkg::MODULE_TYPE_MAM, dbg_mam_pkg::MODULE_VERSION_MAM};
      end else if (index == 8'd1) begin
         return dbg_mam_pkg::MEMORY_ID;
      end
      return 16'h0000;
   endfunction

   // Called on a falling edge, returns on the falling edge after acceptance
   task automatic send_flit(input logic [dbg_mam_pkg::FLIT_WIDTH-1:0] flit);
      noc_in_flit_i = flit;
      noc_in_valid_i = 1'b1;
      while (!noc_in_ready_o) begin
         stall_count++;
         @(negedge clk);
      end
      @(negedge clk);
   endtask

   task automatic send_write(input logic [31:0] addr, input int pairs);
      dbg_mam_pkg::flit_content_u c;
      logic [31:0] data;
      logic [1:0] ftype;
      c.hdr.dest = MAM_ADDR;
      c.hdr.pclass = dbg_mam_pkg::CLASS_MEM_WRITE;
      c.hdr.sub = 8'h00;
      send_flit({dbg_mam_pkg::FLIT_TYPE_HEADER, c});
      c.payload = addr[31:16];
      send_flit({TYPE_PAYLOAD, c});
      c.payload = addr[15:0];
      send_flit({TYPE_PAYLOAD, c});
      for (int k = 0; k < pairs; k++) begin
         data = take_bits(data_lfsr, 32);
         // One word further per pair
         write_q.push_back({addr + 32'(k) * 32'd4, data});
         update_heads();
         c.payload = data[31:16];
         send_flit({TYPE_PAYLOAD, c});
         ftype = (k == pairs - 1) ? dbg_mam_pkg::FLIT_TYPE_LAST : TYPE_PAYLOAD;
         c.payload = data[15:0];
         send_flit({ftype, c});
      end
      noc_in_valid_i = 1'b0;
   endtask

   // Same shape as a write packet, but the header must be ignored
   task automatic send_ignored(input logic [2:0] pclass, input logic [7:0] sub);
      dbg_mam_pkg::flit_content_u c;
      c.hdr.dest = MAM_ADDR;
      c.hdr.pclass = pclass;
      c.hdr.sub = sub;
      send_flit({dbg_mam_pkg::FLIT_TYPE_HEADER, c});
      for (int k = 0; k < 4; k++) begin
         c.payload = take_bits(data_lfsr, 16);
         send_flit({(k == 3) ? dbg_mam_pkg::FLIT_TYPE_LAST : TYPE_PAYLOAD, c});
      end
      noc_in_valid_i = 1'b0;
   endtask

   task automatic read_conf(input logic [7:0] index, input logic [4:0] requester,
                            input int hold_cycles);
      dbg_mam_pkg::flit_content_u c;
      c.hdr.dest = requester;
      c.hdr.pclass = dbg_mam_pkg::CLASS_CONF;
      c.hdr.sub = index;
      reply_q.push_back({dbg_mam_pkg::FLIT_TYPE_HEADER, c});
      reply_q.push_back({dbg_mam_pkg::FLIT_TYPE_LAST, expected_reg(index)});
      update_heads();
      c.hdr.dest = MAM_ADDR;
      send_flit({dbg_mam_pkg::FLIT_TYPE_HEADER, c});
      c.payload = {11'h000, requester};
      send_flit({dbg_mam_pkg::FLIT_TYPE_LAST, c});
      // Responder only gets the output with the input quiet
      noc_in_valid_i = 1'b0;
      if (hold_cycles > 0) begin
         noc_out_ready_i = 1'b0;
         while (!noc_out_valid_o) @(negedge clk);
         repeat (hold_cycles) @(negedge clk);
         noc_out_ready_i = 1'b1;
      end
      while (reply_q.size() != 0) @(negedge clk);
   endtask

   task automatic wait_writes();
      while (write_q.size() != 0) @(negedge clk);
   endtask

   // --------------------
   // Wishbone slave
   // --------------------

   always @(negedge clk) begin
      if (rst || wb_ack_i) begin
         wb_ack_i = 1'b0;
         ack_armed = 1'b0;
      end else if (wb_stb_o) begin
         if (!ack_armed) begin
            ack_armed = 1'b1;
            ack_delay = slow_ack ? SLOW_ACK_DELAY : int'(take_bits(ack_lfsr, 3) % 6);
         end
         if (ack_delay == 0) begin
            wb_ack_i = 1'b1;
         end else begin
            ack_delay--;
         end
      end
   end

   // Retire expected entries on each handshake
   always @(posedge clk) begin
      if (!rst && wb_stb_o && wb_ack_i) begin
         ack_count++;
         if (write_q.size() != 0) begin
            void'(write_q.pop_front());
         end
         update_heads();
      end
      if (!rst && noc_out_valid_o && noc_out_ready_i && reply_q.size() != 0) begin
         void'(reply_q.pop_front());
         update_heads();
      end
   end

   // --------------------
   // Value checks
   // --------------------

   write_expected: assert property (@(posedge clk) disable iff (rst)
         wb_stb_o && wb_ack_i |-> exp_write_any)
      else begin
         other_errors++;
         $display("Wishbone write to %h arrived with none expected", $sampled(wb_adr_o));
      end

   write_adr: assert property (@(posedge clk) disable iff (rst)
         wb_stb_o && wb_ack_i && exp_write_any |-> wb_adr_o == exp_adr)
      else begin
         write_errors++;
         $display("Error: wb_adr_o expected %h got %h", $sampled(exp_adr), $sampled(wb_adr_o));
      end

   write_dat: assert property (@(posedge clk) disable iff (rst)
         wb_stb_o && wb_ack_i && exp_write_any |-> wb_dat_o == exp_dat)
      else begin
         write_errors++;
         $display("Error: wb_dat_o expected %h got %h", $sampled(exp_dat), $sampled(wb_dat_o));
      end

   // Full-word write on every strobe
   write_lanes: assert property (@(posedge clk) disable iff (rst)
         wb_stb_o |-> wb_we_o && wb_sel_o == 4'hf)
      else begin
         write_errors++;
         $display("Error: wb_sel_o expected f got %h, wb_we_o expected 1 got %h",
                  $sampled(wb_sel_o), $sampled(wb_we_o));
      end

   reply_flit: assert property (@(posedge clk) disable iff (rst)
         noc_out_valid_o && noc_out_ready_i |-> exp_reply_any && noc_out_flit_o == exp_flit)
      else begin
         reply_errors++;
         $display("Error: noc_out_flit_o expected %h got %h",
                  $sampled(exp_flit), $sampled(noc_out_flit_o));
      end

   // --------------------
   // Stimulus
   // --------------------

   initial begin
      int acks_before;
      int stalls_before;
      clk = 1'b0;
      rst = 1'b1;
      noc_in_flit_i = '0;
      noc_in_valid_i = 1'b0;
      noc_out_ready_i = 1'b1;
      wb_err_i = 1'b0;
      repeat (3) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      // Single pair, then a burst
      send_write(take_bits(data_lfsr, 32) & 32'hffff_fffc, 1);
      wait_writes();
      send_write(take_bits(data_lfsr, 32) & 32'hffff_fffc, BURST_PAIRS);
      wait_writes();

      // Foreign class and non-zero subfield, then a normal packet
      acks_before = ack_count;
      send_ignored(3'b001, 8'h00);
      send_ignored(dbg_mam_pkg::CLASS_MEM_WRITE, 8'h05);
      repeat (10) @(negedge clk);
      assert (ack_count == acks_before)
         else begin
            other_errors++;
            $display("Ignored headers still started a Wishbone cycle");
         end
      send_write(take_bits(data_lfsr, 32) & 32'hffff_fffc, 1);
      wait_writes();

      read_conf(8'd0, 5'h11, 0);
      read_conf(8'd1, 5'h1a, 0);
      read_conf(8'd5, 5'h03, 0);

      // Responder may still own the output for a cycle
      while (!noc_in_ready_o) @(negedge clk);

      // Slow memory backs up into the network
      slow_ack = 1'b1;
      stalls_before = stall_count;
      send_write(take_bits(data_lfsr, 32) & 32'hffff_fffc, STALL_PAIRS);
      wait_writes();
      slow_ack = 1'b0;
      assert (stall_count > stalls_before)
         else begin
            other_errors++;
            $display("noc_in_ready_o never went low during the slow burst");
         end

      // Reply parked behind a low ready
      read_conf(8'd1, 5'h0c, 6);

      repeat (4) @(negedge clk);
      protocol_errors = dut0.u_asserts.fail_count;
      $display("Checks done: write errors %0d, reply errors %0d, protocol errors %0d, other %0d",
               write_errors, reply_errors, protocol_errors, other_errors);
      if (write_errors + reply_errors + protocol_errors + other_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: dbg_mam.f
logic/dbg_mam_pkg.sv
logic/dbg_conf_regs.sv
logic/mam_write_fifo.sv
logic/mam_wb_master.sv
logic/mam_ctrl.sv
logic/dbg_mam.sv
dv/dbg_mam_asserts.sv
dv/dbg_mam_tb.sv
